// ==== hdl/msk_settings.svh ====
`ifndef MSK_SETTINGS_SVH
`define MSK_SETTINGS_SVH

// clocks per bit period.
`define MSK_SAMPLES_PER_BIT 25

// signed arm amplitude width.
`define MSK_AMP_W 10

// width of the sample index inside one bit period.
`define MSK_SLOT_W 5

// the quarter-wave table spans one bit period, one entry per sample.
`define MSK_ENV_DEPTH `MSK_SAMPLES_PER_BIT

`endif

// ==== hdl/msk_pkg.sv ====
`default_nettype none

`include "msk_settings.svh"

package msk_pkg;

    // signed envelope amplitude of one arm.
    typedef logic signed [`MSK_AMP_W-1:0] amp_t;

    // sigma-delta accumulator, two bits of headroom over the amplitude.
    typedef logic [`MSK_AMP_W+1:0] acc_t;

    // sample position inside a bit period.
    typedef logic [`MSK_SLOT_W-1:0] slot_cnt_t;

    // arm that takes the next bit from the source.
    typedef enum logic {
        ARM_I = 1'b0, // in-phase, even bits.
        ARM_Q = 1'b1  // quadrature, odd bits.
    } arm_t;

endpackage

`default_nettype wire

// ==== hdl/msk_symbol_sequencer.sv ====
`default_nettype none

`include "msk_settings.svh"

module msk_symbol_sequencer
    import msk_pkg::*;
(
    input  wire        clk,
    input  wire        i_arst_n,
    input  wire        i_empty,    // source has no bit.
    input  wire        i_data,     // bit at the head of the source.
    output logic       o_ready,    // one-cycle pop pulse.
    output slot_cnt_t  o_slot_idx, // sample index inside the bit period.
    output logic       o_half_i,   // I arm is in the second half of its symbol.
    output logic       o_half_q,   // Q arm is in the second half of its symbol.
    output logic       o_bit_i,
    output logic       o_bit_q,
    output logic       o_act_i,    // I arm carries a bit, not an idle slot.
    output logic       o_act_q
);

    localparam slot_cnt_t LAST_SLOT = slot_cnt_t'(`MSK_SAMPLES_PER_BIT - 1);

    slot_cnt_t  slot_cnt;
    logic       slot_end;
    arm_t       next_arm;
    arm_t       other_arm;

    // per-arm state, indexed by arm_t.
    logic [1:0] arm_bit;
    logic [1:0] arm_act;
    logic [1:0] arm_half;

    assign slot_end  = (slot_cnt == LAST_SLOT);
    assign other_arm = (next_arm == ARM_I) ? ARM_Q : ARM_I;

    // pop only at a slot end, and only when the source has a bit.
    assign o_ready = slot_end & ~i_empty;

    // sample counter, wraps once per bit period.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            slot_cnt <= '0;
        end else if (slot_end) begin
            slot_cnt <= '0;
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    // the arms take turns, idle slots included.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            next_arm <= ARM_I;
        end else if (slot_end) begin
            next_arm <= other_arm;
        end
    end

    // activity and symbol half.
    // the arm that starts a symbol goes to its first half, the other one
    // to its second half, so each symbol lasts two bit periods.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            arm_act  <= '0;
            arm_half <= '0;
        end else if (slot_end) begin
            arm_act[next_arm]   <= ~i_empty; // empty source gives an idle symbol.
            arm_half[next_arm]  <= 1'b0;
            arm_half[other_arm] <= 1'b1;
        end
    end

    // symbol bit, loaded on the pop edge.
    always_ff @(posedge clk) begin
        if (o_ready) begin
            arm_bit[next_arm] <= i_data;
        end
    end

    assign o_slot_idx = slot_cnt;
    assign o_bit_i    = arm_bit[ARM_I];
    assign o_bit_q    = arm_bit[ARM_Q];
    assign o_act_i    = arm_act[ARM_I];
    assign o_act_q    = arm_act[ARM_Q];
    assign o_half_i   = arm_half[ARM_I];
    assign o_half_q   = arm_half[ARM_Q];

endmodule

`default_nettype wire

// ==== hdl/msk_half_sine.sv ====
`default_nettype none

`include "msk_settings.svh"

module msk_half_sine
    import msk_pkg::*;
(
    input  wire        clk,
    input  wire        i_arst_n,
    input  slot_cnt_t  i_slot_idx, // sample index inside the bit period.
    input  wire        i_half_i,
    input  wire        i_half_q,
    input  wire        i_bit_i,
    input  wire        i_bit_q,
    input  wire        i_act_i,
    input  wire        i_act_q,
    output amp_t       o_amp_i,    // registered signed I amplitude.
    output amp_t       o_amp_q     // registered signed Q amplitude.
);

    localparam int MAG_W = `MSK_AMP_W - 1;

    // quarter wave, sampled at the middle of each clock.
    // entry k is round(511 * sin(pi * (k + 0.5) / 50)).
    localparam logic [MAG_W-1:0] ENV_TABLE [`MSK_ENV_DEPTH] = '{
        9'd16,  9'd48,  9'd80,  9'd111, 9'd143,
        9'd173, 9'd203, 9'd232, 9'd260, 9'd287,
        9'd313, 9'd338, 9'd361, 9'd383, 9'd404,
        9'd423, 9'd440, 9'd455, 9'd469, 9'd481,
        9'd491, 9'd499, 9'd505, 9'd509, 9'd511
    };

    // amplitude of one arm at the current sample.
    function automatic amp_t arm_amp(
        input slot_cnt_t idx,
        input logic      half,
        input logic      bit_val,
        input logic      act
    );
        slot_cnt_t tab_idx;
        amp_t      mag;
        // rising half reads forward, falling half reads backward.
        tab_idx = half ? (slot_cnt_t'(`MSK_ENV_DEPTH - 1) - idx) : idx;
        mag     = amp_t'({1'b0, ENV_TABLE[tab_idx]});
        if (!act) begin
            return '0; // idle arm sits at zero.
        end else if (bit_val) begin
            return mag;
        end else begin
            return -mag; // bit 0 is the negative half-sine.
        end
    endfunction

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_amp_i <= '0;
            o_amp_q <= '0;
        end else begin
            o_amp_i <= arm_amp(i_slot_idx, i_half_i, i_bit_i, i_act_i);
            o_amp_q <= arm_amp(i_slot_idx, i_half_q, i_bit_q, i_act_q);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/msk_sigma_delta.sv ====
`default_nettype none

`include "msk_settings.svh"

module msk_sigma_delta
    import msk_pkg::*;
(
    input  wire   clk,
    input  wire   i_arst_n,
    input  amp_t  i_amp,   // signed amplitude, one sample per clock.
    output logic  o_bit    // one-bit bitstream for the external RC filter.
);

    localparam int W = `MSK_AMP_W;

    acc_t acc_q;
    acc_t amp_u;
    acc_t sum;
    acc_t acc_next;
    logic carry;

    // offset binary: flipping the sign bit adds half scale.
    // zero maps to half scale, which gives a 50 % ones density.
    assign amp_u = {2'b00, ~i_amp[W-1], i_amp[W-2:0]};

    assign sum   = acc_q + amp_u;
    assign carry = sum[W]; // overflow past full scale.

    // keep the remainder for the next sample.
    assign acc_next = sum - (acc_t'(carry) << W);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            acc_q <= '0;
            o_bit <= 1'b0;
        end else begin
            acc_q <= acc_next;
            o_bit <= carry;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/msk_modulator.sv ====
`default_nettype none

`include "msk_settings.svh"

module msk_modulator
    import msk_pkg::*;
(
    input  wire   clk,
    input  wire   i_arst_n,
    input  wire   i_empty,      // source FIFO is empty.
    input  wire   i_data,       // bit at the FIFO head.
    output logic  o_ready,      // FIFO pop pulse.
    output logic  o_sin_i,      // I arm bitstream.
    output logic  o_sin_q,      // Q arm bitstream.
    output logic  o_sin_i_sign, // I arm polarity.
    output logic  o_sin_q_sign  // Q arm polarity.
);

    slot_cnt_t slot_idx;
    logic      half_i;
    logic      half_q;
    logic      bit_i;
    logic      bit_q;
    logic      act_i;
    logic      act_q;
    amp_t      amp_i;
    amp_t      amp_q;

    msk_symbol_sequencer seq0 (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_empty    (i_empty),
        .i_data     (i_data),
        .o_ready    (o_ready),
        .o_slot_idx (slot_idx),
        .o_half_i   (half_i),
        .o_half_q   (half_q),
        .o_bit_i    (bit_i),
        .o_bit_q    (bit_q),
        .o_act_i    (act_i),
        .o_act_q    (act_q)
    );

    msk_half_sine env0 (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_slot_idx (slot_idx),
        .i_half_i   (half_i),
        .i_half_q   (half_q),
        .i_bit_i    (bit_i),
        .i_bit_q    (bit_q),
        .i_act_i    (act_i),
        .i_act_q    (act_q),
        .o_amp_i    (amp_i),
        .o_amp_q    (amp_q)
    );

    msk_sigma_delta sd_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_amp    (amp_i),
        .o_bit    (o_sin_i)
    );

    msk_sigma_delta sd_q (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_amp    (amp_q),
        .o_bit    (o_sin_q)
    );

    // polarity follows the symbol bit, and an idle arm reads as 0.
    assign o_sin_i_sign = bit_i & act_i;
    assign o_sin_q_sign = bit_q & act_q;

endmodule

`default_nettype wire

// ==== verif/msk_checker.sv ====
`default_nettype none

`include "msk_settings.svh"

module msk_checker (
    input  wire clk,
    input  wire i_arst_n,
    input  wire i_empty,
    input  wire i_data,
    input  wire i_ready,
    input  wire i_sin_i,
    input  wire i_sin_q,
    input  wire i_sin_i_sign,
    input  wire i_sin_q_sign,
    output int  o_ready_errs,
    output int  o_sign_errs,
    output int  o_stream_errs,
    output int  o_active_windows, // finished bitstream windows of data symbols.
    output int  o_idle_windows    // finished bitstream windows of idle symbols.
);

    localparam int SPB = `MSK_SAMPLES_PER_BIT;
    localparam int SYM = 2 * SPB; // symbol length in clocks.

    int         slot_pos;      // expected sample index in the bit period.
    int         next_arm;      // 0 is I, 1 is Q.
    logic       slot_end;
    logic       exp_ready;
    logic       exp_bit  [2];
    logic       exp_act  [2];
    logic       started  [2];  // arm has had its first slot end.
    int         phase    [2];  // clocks since the arm's last slot end.
    logic       win_on   [2];  // a bitstream window is being counted.
    logic       win_act  [2];
    logic       win_bit  [2];
    int         win_ones [2];
    int         ones_hi;       // last bit-1 count, -1 before the first.
    int         ones_lo;       // last bit-0 count, -1 before the first.
    logic [1:0] sin_now;
    logic [1:0] sign_now;

    // judge the ones count of one finished symbol window.
    task automatic judge_window(input int a, input int ones);
        string name;
        name = (a == 0) ? "o_sin_i" : "o_sin_q";
        if (!win_act[a]) begin
            o_idle_windows++;
            assert (ones >= SPB - 1 && ones <= SPB + 1) else begin
                o_stream_errs++;
                $display("FAIL %s idle ones: got %h, expected %h +/- 1", name, ones, SPB);
            end
        end else begin
            o_active_windows++;
            if (win_bit[a]) begin
                assert (ones > SPB) else begin
                    o_stream_errs++;
                    $display("FAIL %s bit-1 ones: got %h, expected above %h", name, ones, SPB);
                end
                ones_hi = ones;
            end else begin
                assert (ones < SPB) else begin
                    o_stream_errs++;
                    $display("FAIL %s bit-0 ones: got %h, expected below %h", name, ones, SPB);
                end
                ones_lo = ones;
            end
            // positive and negative half-sines balance around half density.
            if (ones_hi >= 0 && ones_lo >= 0) begin
                assert (ones_hi + ones_lo >= SYM - 2 && ones_hi + ones_lo <= SYM + 2) else begin
                    o_stream_errs++;
                    $display("%s: bit-1 count %0d and bit-0 count %0d are not mirrored about %0d",
                             name, ones_hi, ones_lo, SPB);
                end
            end
        end
    endtask

    always @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            slot_pos = 0;
            next_arm = 0;
            ones_hi  = -1;
            ones_lo  = -1;
            for (int a = 0; a < 2; a++) begin
                exp_bit[a]  = 1'b0;
                exp_act[a]  = 1'b0;
                started[a]  = 1'b0;
                phase[a]    = 0;
                win_on[a]   = 1'b0;
                win_ones[a] = 0;
            end
        end else begin
            sin_now   = {i_sin_q, i_sin_i};
            sign_now  = {i_sin_q_sign, i_sin_i_sign};
            slot_end  = (slot_pos == SPB - 1);
            exp_ready = slot_end && !i_empty;

            assert (i_ready === exp_ready) else begin
                o_ready_errs++;
                $display("FAIL o_ready at %0t: got %h, expected %h", $time, i_ready, exp_ready);
            end

            for (int a = 0; a < 2; a++) begin
                assert (sign_now[a] === (exp_bit[a] & exp_act[a])) else begin
                    o_sign_errs++;
                    $display("FAIL %s at %0t: got %h, expected %h",
                             (a == 0) ? "o_sin_i_sign" : "o_sin_q_sign", $time,
                             sign_now[a], exp_bit[a] & exp_act[a]);
                end
                // bitstream is two clocks behind the symbol and read one clock late,
                // so a window runs from phase 2 round to phase 1.
                if (started[a]) begin
                    if (phase[a] == 2) begin
                        win_on[a]   = 1'b1;
                        win_act[a]  = exp_act[a];
                        win_bit[a]  = exp_bit[a];
                        win_ones[a] = sin_now[a] ? 1 : 0;
                    end else if (win_on[a]) begin
                        win_ones[a] += sin_now[a] ? 1 : 0;
                        if (phase[a] == 1) begin
                            judge_window(a, win_ones[a]);
                            win_on[a] = 1'b0;
                        end
                    end
                    phase[a]++;
                end
            end

            // expected symbol state after this edge.
            if (slot_end) begin
                exp_act[next_arm] = !i_empty;
                if (!i_empty) begin
                    exp_bit[next_arm] = i_data;
                end
                phase[next_arm]   = 0;
                started[next_arm] = 1'b1;
                next_arm          = 1 - next_arm;
                slot_pos          = 0;
            end else begin
                slot_pos++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/msk_modulator_tb.sv ====
`default_nettype none

`include "msk_settings.svh"

module msk_modulator_tb;

    localparam int SPB        = `MSK_SAMPLES_PER_BIT;
    localparam int BURST_A    = 24;
    localparam int GAP_BITS   = 17;  // bit periods with an empty source.
    localparam int BURST_B    = 11;
    localparam int TAIL_BITS  = 4;
    localparam int MAX_CYCLES = (BURST_A + GAP_BITS + BURST_B + TAIL_BITS) * SPB + 200;

    logic   clk;
    logic   i_arst_n;
    logic   i_empty;
    logic   i_data;
    logic   o_ready;
    logic   o_sin_i;
    logic   o_sin_q;
    logic   o_sin_i_sign;
    logic   o_sin_q_sign;

    integer seed;
    bit     fifo_q[$];      // source FIFO contents with the head at index 0.
    logic   ready_seen;
    int     pushed;
    int     popped;
    int     fifo_errs;
    int     total_errs;
    int     cycles;
    int     ready_errs;
    int     sign_errs;
    int     stream_errs;
    int     active_windows;
    int     idle_windows;

    msk_modulator dut0 (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_empty      (i_empty),
        .i_data       (i_data),
        .o_ready      (o_ready),
        .o_sin_i      (o_sin_i),
        .o_sin_q      (o_sin_q),
        .o_sin_i_sign (o_sin_i_sign),
        .o_sin_q_sign (o_sin_q_sign)
    );

    msk_checker chk0 (
        .clk              (clk),
        .i_arst_n         (i_arst_n),
        .i_empty          (i_empty),
        .i_data           (i_data),
        .i_ready          (o_ready),
        .i_sin_i          (o_sin_i),
        .i_sin_q          (o_sin_q),
        .i_sin_i_sign     (o_sin_i_sign),
        .i_sin_q_sign     (o_sin_q_sign),
        .o_ready_errs     (ready_errs),
        .o_sign_errs      (sign_errs),
        .o_stream_errs    (stream_errs),
        .o_active_windows (active_windows),
        .o_idle_windows   (idle_windows)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // push n random bits into the source.
    task automatic load_burst(input int n);
        integer r;
        for (int k = 0; k < n; k++) begin
            r = $random(seed);
            fifo_q.push_back(r[0]);
        end
        pushed += n;
    endtask

    task automatic wait_source_drained();
        while (fifo_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // the source FIFO pops on the pulse and then presents the new head.
    always @(posedge clk) begin
        ready_seen = o_ready;
        #2;
        if (ready_seen) begin
            if (fifo_q.size() > 0) begin
                void'(fifo_q.pop_front());
                popped++;
            end else begin
                fifo_errs++;
                $display("o_ready pulsed at %0t while the source held no bit", $time);
            end
        end
        i_empty = (fifo_q.size() == 0);
        i_data  = i_empty ? 1'b0 : fifo_q[0];
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        seed     = 32'hdc76_1183;
        i_arst_n = 1'b0;
        i_empty  = 1'b1;
        i_data   = 1'b0;
        repeat (3) @(posedge clk);
        #2 i_arst_n = 1'b1;
        @(posedge clk);

        load_burst(BURST_A);
        wait_source_drained();
        repeat (GAP_BITS * SPB) @(posedge clk); // idle symbols on both arms.
        load_burst(BURST_B);
        wait_source_drained();
        repeat (TAIL_BITS * SPB) @(posedge clk); // let the last windows close.

        if (popped != pushed) begin
            fifo_errs++;
            $display("only %0d of %0d source bits were popped", popped, pushed);
        end
        if (active_windows == 0 || idle_windows == 0) begin
            fifo_errs++;
            $display("bitstream windows were not all reached: %0d active, %0d idle",
                     active_windows, idle_windows);
        end

        total_errs = ready_errs + sign_errs + stream_errs + fifo_errs;
        $display("errors: ready %0d, sign %0d, bitstream %0d, source %0d, total %0d",
                 ready_errs, sign_errs, stream_errs, fifo_errs, total_errs);
        if (total_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hdl
hdl/msk_pkg.sv
hdl/msk_symbol_sequencer.sv
hdl/msk_half_sine.sv
hdl/msk_sigma_delta.sv
hdl/msk_modulator.sv
verif/msk_checker.sv
verif/msk_modulator_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the MSK modulator testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert --top-module msk_modulator_tb -f files.f -o msk_sim \
    > build.log 2>&1 &&
./obj_dir/msk_sim > sim.log 2>&1 ||
{ cat build.log; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0
